/* common/mic_array_pkg.sv */
package mic_array_pkg;

  // PCM and tone words
  typedef logic signed [15:0] sample_t;
  typedef logic signed [7:0]  tone_t;

  // Latest sample of every microphone
  typedef struct packed {
    sample_t mic1;
    sample_t mic2;
    sample_t mic3;
  } mic_frame_t;

  // PCM source feeding the PDM modulator
  typedef enum logic [1:0] {
    src_mic1 = 2'd0,
    src_dec  = 2'd1,
    src_tone = 2'd2,
    src_mute = 2'd3
  } src_sel_e;

  // I2S timing
  localparam int BCLK_DIV    = 16;  // Audio clocks per half bit clock
  localparam int BCLK_CNT_W  = $clog2(BCLK_DIV);
  localparam int SLOT_BITS   = 32;  // Bit clocks per ws half frame
  localparam int FRAME_CNT_W = $clog2(2 * SLOT_BITS);
  localparam int SAMPLE_BITS = 16;

  // Tone tick at roughly 24 kHz from the 98.3 MHz audio clock
  localparam int TONE_TICK_BITS = 12;

  // 440 / 24000 * 2^32
  localparam logic [31:0] TONE_INCR_440 = 32'h04B1_7E4B;

  // First quadrant of 127 * sin(2*pi*k/256), k = 0..63
  localparam logic [6:0] QUARTER_SINE [64] = '{
    7'd0,   7'd3,   7'd6,   7'd9,   7'd12,  7'd16,  7'd19,  7'd22,
    7'd25,  7'd28,  7'd31,  7'd34,  7'd37,  7'd40,  7'd43,  7'd46,
    7'd49,  7'd51,  7'd54,  7'd57,  7'd60,  7'd63,  7'd65,  7'd68,
    7'd71,  7'd73,  7'd76,  7'd78,  7'd81,  7'd83,  7'd85,  7'd88,
    7'd90,  7'd92,  7'd94,  7'd96,  7'd98,  7'd100, 7'd102, 7'd104,
    7'd106, 7'd107, 7'd109, 7'd111, 7'd112, 7'd113, 7'd115, 7'd116,
    7'd117, 7'd118, 7'd120, 7'd121, 7'd122, 7'd122, 7'd123, 7'd124,
    7'd125, 7'd125, 7'd126, 7'd126, 7'd126, 7'd127, 7'd127, 7'd127
  };

  // Peak value at the quadrant boundary, not held in the table
  localparam logic [6:0] SINE_PEAK = 7'd127;

endpackage

/* i2s_rx/i2s_rx.sv */
`timescale 1ns/1ps

module i2s_rx (
  input  logic                  audio_clk,
  input  logic                  arst_n,
  input  logic                  sd,
  output logic                  bclk,
  output logic                  ws,
  output logic                  valid,
  output mic_array_pkg::sample_t sample
);

  logic [mic_array_pkg::BCLK_CNT_W-1:0]  div_cnt;
  logic [mic_array_pkg::FRAME_CNT_W-1:0] bit_cnt;
  logic [mic_array_pkg::FRAME_CNT_W-1:0] bit_nxt;
  logic                                  half_done;
  logic                                  bclk_rise;
  logic                                  bclk_fall;
  logic                                  capture;
  logic                                  last_bit;

  assign half_done = (div_cnt == mic_array_pkg::BCLK_DIV - 1);
  assign bclk_rise = half_done & ~bclk;
  assign bclk_fall = half_done & bclk;
  assign bit_nxt   = bit_cnt + 1'b1;

  // Left slot bits 1..16, bit 0 is the I2S delay bit after ws falls
  assign capture  = bclk_rise && (bit_cnt >= 1) && (bit_cnt <= mic_array_pkg::SAMPLE_BITS);
  assign last_bit = (bit_cnt == mic_array_pkg::SAMPLE_BITS);

  // Bit clock divider
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      bclk    <= 1'b0;
    end else begin
      div_cnt <= half_done ? '0 : div_cnt + 1'b1;
      if (half_done) begin
        bclk <= ~bclk;
      end
    end
  end

  // Frame position advances on the falling edge, so ws moves with bclk low
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
      ws      <= 1'b0;
    end else if (bclk_fall) begin
      bit_cnt <= bit_nxt;
      ws      <= (bit_nxt >= mic_array_pkg::SLOT_BITS);  // High for the right slot
    end
  end

  // MSB first shift, the word is complete once valid rises
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      sample <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= capture & last_bit;
      if (capture) begin
        sample <= {sample[14:0], sd};
      end
    end
  end

endmodule

/* hdl/sine_gen.sv */
`timescale 1ns/1ps

module sine_gen #(
  parameter logic [31:0] PHASE_INCR = mic_array_pkg::TONE_INCR_440
) (
  input  logic                 audio_clk,
  input  logic                 arst_n,
  input  logic                 step,
  output mic_array_pkg::tone_t tone
);

  logic [31:0]       phase;
  logic [31:0]       phase_nxt;
  logic [7:0]        index;
  logic [6:0]        addr;
  logic [6:0]        mag;
  logic signed [7:0] mag_s;
  logic              negate;

  assign phase_nxt = phase + PHASE_INCR;
  assign index     = phase_nxt[31:24];
  assign negate    = index[7];  // Second half of the period

  // Odd quadrants read the table backwards
  assign addr = index[6] ? (7'd64 - {1'b0, index[5:0]}) : {1'b0, index[5:0]};

  // Address 64 only occurs when mirrored and is the peak
  assign mag   = addr[6] ? mic_array_pkg::SINE_PEAK : mic_array_pkg::QUARTER_SINE[addr[5:0]];
  assign mag_s = {1'b0, mag};

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= '0;
      tone  <= '0;
    end else if (step) begin
      phase <= phase_nxt;
      tone  <= negate ? -mag_s : mag_s;  // New phase shows up with the tone
    end
  end

endmodule

/* hdl/decimator.sv */
`timescale 1ns/1ps

module decimator (
  input  logic                   audio_clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  input  mic_array_pkg::sample_t in_sample,
  output logic                   out_valid,
  output mic_array_pkg::sample_t out_sample
);

  mic_array_pkg::sample_t prev_sample;
  logic                   odd_phase;  // Set after every first input of a pair
  logic signed [16:0]     sum;

  // One extra bit so two full scale samples never wrap
  assign sum = in_sample + prev_sample;

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_sample <= '0;
      odd_phase   <= 1'b0;
    end else if (in_valid) begin
      prev_sample <= in_sample;
      odd_phase   <= ~odd_phase;
    end
  end

  // Average is kept on every second input only
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid  <= 1'b0;
      out_sample <= '0;
    end else begin
      out_valid <= in_valid & odd_phase;
      if (in_valid && odd_phase) begin
        out_sample <= sum[16:1];  // Arithmetic shift right by one
      end
    end
  end

endmodule

/* hdl/pdm_mod.sv */
`timescale 1ns/1ps

module pdm_mod (
  input  logic                   audio_clk,
  input  logic                   arst_n,
  input  mic_array_pkg::sample_t pcm,
  output logic                   pdm
);

  logic [15:0] pcm_offset;
  logic [15:0] err_acc;
  logic [16:0] acc_sum;

  // Two's complement to offset binary, -32768 maps to zero
  assign pcm_offset = {~pcm[15], pcm[14:0]};

  assign acc_sum = {1'b0, err_acc} + {1'b0, pcm_offset};

  // First order loop, the carry out is the density bit
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      err_acc <= '0;
      pdm     <= 1'b0;
    end else begin
      err_acc <= acc_sum[15:0];
      pdm     <= acc_sum[16];
    end
  end

endmodule

/* hdl/mic_array_top.sv */
`timescale 1ns/1ps

module mic_array_top (
  input  logic                       audio_clk,
  input  logic                       arst_n,
  input  logic [2:0]                 mic_sd,
  output logic [2:0]                 mic_bclk,
  output logic [2:0]                 mic_ws,
  input  mic_array_pkg::src_sel_e    src_sel,
  input  logic [1:0]                 spk_en,
  output mic_array_pkg::mic_frame_t  mics,
  output logic                       dec_valid,
  output mic_array_pkg::sample_t     dec_sample,
  output mic_array_pkg::sample_t     pcm_out,
  output logic                       spk_l,
  output logic                       spk_r
);

  logic [2:0]                           rx_valid;
  mic_array_pkg::sample_t               rx_sample [3];
  logic [mic_array_pkg::TONE_TICK_BITS-1:0] tick_cnt;
  logic                                 tone_tick;
  mic_array_pkg::tone_t                 tone;
  logic                                 pdm_bit;

  // One receiver per microphone, index 0 is microphone 1
  for (genvar i = 0; i < 3; i++) begin : g_rx
    i2s_rx u_i2s_rx (
      .audio_clk (audio_clk),
      .arst_n    (arst_n),
      .sd        (mic_sd[i]),
      .bclk      (mic_bclk[i]),
      .ws        (mic_ws[i]),
      .valid     (rx_valid[i]),
      .sample    (rx_sample[i])
    );
  end

  // Hold the latest word of each microphone
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      mics <= '0;
    end else begin
      if (rx_valid[0]) mics.mic1 <= rx_sample[0];
      if (rx_valid[1]) mics.mic2 <= rx_sample[1];
      if (rx_valid[2]) mics.mic3 <= rx_sample[2];
    end
  end

  // Free running tick counter, one pulse per wrap
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  assign tone_tick = &tick_cnt;

  sine_gen u_sine_gen (
    .audio_clk (audio_clk),
    .arst_n    (arst_n),
    .step      (tone_tick),
    .tone      (tone)
  );

  decimator u_decimator (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .in_valid   (rx_valid[0]),
    .in_sample  (rx_sample[0]),
    .out_valid  (dec_valid),
    .out_sample (dec_sample)
  );

  // Registered source select
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      pcm_out <= '0;
    end else begin
      case (src_sel)
        mic_array_pkg::src_mic1: pcm_out <= mics.mic1;
        mic_array_pkg::src_dec:  pcm_out <= dec_sample;
        mic_array_pkg::src_tone: pcm_out <= {tone, 8'h00};  // Tone to full scale
        default:                 pcm_out <= '0;
      endcase
    end
  end

  pdm_mod u_pdm_mod (
    .audio_clk (audio_clk),
    .arst_n    (arst_n),
    .pcm       (pcm_out),
    .pdm       (pdm_bit)
  );

  assign spk_l = spk_en[0] & pdm_bit;
  assign spk_r = spk_en[1] & pdm_bit;

endmodule

/* bench/mic_array_chk.sv */
`timescale 1ns/1ps

module mic_array_chk (
  input logic       audio_clk,
  input logic       arst_n,
  input logic [2:0] rx_valid,
  input logic [2:0] mic_bclk,
  input logic [2:0] mic_ws,
  input logic       dec_valid
);

  logic rx1_d;   // Cycle where a decimator output may appear
  logic paired;  // Last microphone 1 word produced an output

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx1_d  <= 1'b0;
      paired <= 1'b0;
    end else begin
      rx1_d <= rx_valid[0];
      if (rx1_d) begin
        paired <= dec_valid;
      end
    end
  end

  for (genvar i = 0; i < 3; i++) begin : g_rx_chk
    a_valid_pulse: assert property (@(posedge audio_clk) disable iff (!arst_n)
      rx_valid[i] |=> !rx_valid[i])
      else $error("Receiver %0d valid longer than one cycle", i);

    a_ws_bclk_low: assert property (@(posedge audio_clk) disable iff (!arst_n)
      $changed(mic_ws[i]) |-> !mic_bclk[i])
      else $error("Receiver %0d ws moved while bclk high", i);
  end

  a_dec_alternate: assert property (@(posedge audio_clk) disable iff (!arst_n)
    rx1_d && paired |-> !dec_valid)
    else $error("Decimator output on two microphone 1 words in a row");

endmodule

/* bench/mic_array_checker.sv */
`timescale 1ns/1ps

module mic_array_checker (
  input logic                      audio_clk,
  input logic                      arst_n,
  input logic [2:0]                mic_ws,
  input mic_array_pkg::src_sel_e   src_sel,
  input logic [1:0]                spk_en,
  input mic_array_pkg::mic_frame_t mics,
  input logic                      dec_valid,
  input mic_array_pkg::sample_t    dec_sample,
  input mic_array_pkg::sample_t    pcm_out,
  input logic                      spk_l,
  input logic                      spk_r,
  input mic_array_pkg::mic_frame_t sent,  // Words the microphone models sent this frame
  input logic [1:0]                mode   // 1 tone, 2 PDM window
);

  localparam int PDM_WINDOW = 1024;

  int  check_cnt = 0;
  int  err_cnt = 0;
  int  test_cnt = 0;
  int  base_checks = 0;
  int  base_errs = 0;
  int  cap_cnt [3] = '{0, 0, 0};
  int  dec_cnt = 0;
  int  tone_checks = 0;
  int  pdm_ones = 0;
  int  pdm_win = 0;
  bit  pdm_done = 0;
  int  cyc;
  int  dec_exp = 0;  // Average of the last complete microphone 1 pair
  logic [2:0] ws_q;
  logic [31:0] phase;
  mic_array_pkg::src_sel_e src_q;
  mic_array_pkg::sample_t  prev_mic1 = '0;

  function automatic int ref_dec(int a, int b);
    return (a + b) >>> 1;  // Floor of the average
  endfunction

  function automatic int ref_tone(int index);
    real x;
    x = 127.0 * $sin(2.0 * 3.14159265358979 * index / 256.0);
    return (x >= 0.0) ? $rtoi(x + 0.5) : -$rtoi(0.5 - x);
  endfunction

  function automatic int ref_pdm_count(int pcm, int n);
    return ((pcm + 32768) * n) / 65536;
  endfunction

  function automatic mic_array_pkg::sample_t field(mic_array_pkg::mic_frame_t f, int i);
    case (i)
      0:       return f.mic1;
      1:       return f.mic2;
      default: return f.mic3;
    endcase
  endfunction

  task automatic compare_value(string name, int expected, int actual);
    check_cnt++;
    if (expected != actual) begin
      err_cnt++;
      $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic report_failure(string what);
    check_cnt++;
    err_cnt++;
    $display("Error: %s", what);
  endtask

  task automatic end_test(string name);
    test_cnt++;
    $display("%s: %0d checks, %0d errors, %s", name, check_cnt - base_checks,
             err_cnt - base_errs, (err_cnt == base_errs) ? "ok" : "failed");
    base_checks = check_cnt;
    base_errs   = err_cnt;
  endtask

  task automatic summary();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
  endtask

  // pcm_out follows the source selected one cycle earlier
  task automatic check_source();
    case (src_q)
      mic_array_pkg::src_mic1: compare_value("source select mic1", sent.mic1, pcm_out);
      mic_array_pkg::src_dec:  compare_value("source select dec", dec_exp, pcm_out);
      mic_array_pkg::src_mute: compare_value("source select mute", 0, pcm_out);
      default: ;
    endcase
  endtask

  // Sample on the rising edge, outputs still hold last cycle's values
  always @(posedge audio_clk) begin
    if (!arst_n) begin
      cyc    = 0;
      ws_q   = '0;
      src_q  = mic_array_pkg::src_mute;
    end else begin
      if (dec_valid) begin
        compare_value("decimation", ref_dec(prev_mic1, sent.mic1), dec_sample);
        dec_cnt++;
      end
      for (int i = 0; i < 3; i++) begin
        if (mic_ws[i] && !ws_q[i]) begin  // Right slot started, left word is held
          compare_value($sformatf("capture mic%0d", i + 1), field(sent, i), field(mics, i));
          cap_cnt[i]++;
          if (i == 0) begin
            if (cap_cnt[0] % 2 == 0) begin  // Second word of a pair
              dec_exp = ref_dec(prev_mic1, sent.mic1);
            end
            prev_mic1 = sent.mic1;
            check_source();
          end
        end
      end
      ws_q = mic_ws;
      // Tone k reaches pcm_out on cycle 4096k+1
      if (mode == 2'd1 && src_q == mic_array_pkg::src_tone && cyc > 4096 && cyc % 4096 == 1) begin
        phase = 32'(cyc / 4096) * mic_array_pkg::TONE_INCR_440;
        compare_value("tone", ref_tone(phase[31:24]) * 256, pcm_out);
        tone_checks++;
      end
      if (mode == 2'd2 && pdm_win < PDM_WINDOW) begin
        pdm_ones += spk_l;
        pdm_win++;
        if (pdm_win == PDM_WINDOW) begin
          if (pdm_ones - ref_pdm_count(sent.mic1, PDM_WINDOW) > 1 ||
              ref_pdm_count(sent.mic1, PDM_WINDOW) - pdm_ones > 1) begin
            compare_value("pdm density", ref_pdm_count(sent.mic1, PDM_WINDOW), pdm_ones);
          end else begin
            check_cnt++;
          end
          pdm_done = 1;
        end
      end
      if (!spk_en[0] && spk_l) report_failure("spk_l is high while disabled");
      if (!spk_en[1] && spk_r) report_failure("spk_r is high while disabled");
      src_q = src_sel;
      cyc++;
    end
  end

endmodule

/* bench/mic_array_tb.sv */
`timescale 1ns/1ps

module mic_array_tb;

  localparam int FRAME_CYCLES = 4 * mic_array_pkg::SLOT_BITS * mic_array_pkg::BCLK_DIV;
  localparam int TICK_CYCLES  = 1 << mic_array_pkg::TONE_TICK_BITS;
  localparam int FRAMES_USED  = 15;
  localparam int TICKS_USED   = 22;
  localparam real LIMIT_NS    = 4.0 * (FRAMES_USED * FRAME_CYCLES + TICKS_USED * TICK_CYCLES
                                       + 1024 + 5000);
  localparam logic [15:0] HOLD_WORD = 16'h2000;

  logic                       audio_clk = 1'b0;
  logic                       arst_n;
  logic [2:0]                 mic_sd;
  logic [2:0]                 mic_bclk;
  logic [2:0]                 mic_ws;
  mic_array_pkg::src_sel_e    src_sel;
  logic [1:0]                 spk_en;
  mic_array_pkg::mic_frame_t  mics;
  logic                       dec_valid;
  mic_array_pkg::sample_t     dec_sample;
  mic_array_pkg::sample_t     pcm_out;
  logic                       spk_l;
  logic                       spk_r;
  logic [1:0]                 mode;
  logic                       hold_mic1;
  integer                     seed = 95;
  logic [15:0]                sent [3];
  logic [2:0]                 bclk_q;
  int                         pos [3];
  mic_array_pkg::mic_frame_t  sent_frame;

  assign sent_frame = {sent[0], sent[1], sent[2]};

  always #2 audio_clk = ~audio_clk;

  mic_array_top u_mic_array_top (.*);

  mic_array_checker u_checker (
    .audio_clk (audio_clk), .arst_n (arst_n), .mic_ws (mic_ws), .src_sel (src_sel),
    .spk_en (spk_en), .mics (mics), .dec_valid (dec_valid), .dec_sample (dec_sample),
    .pcm_out (pcm_out), .spk_l (spk_l), .spk_r (spk_r), .sent (sent_frame), .mode (mode)
  );

  bind mic_array_top mic_array_chk u_mic_array_chk (
    .audio_clk (audio_clk), .arst_n (arst_n), .rx_valid (rx_valid),
    .mic_bclk (mic_bclk), .mic_ws (mic_ws), .dec_valid (dec_valid)
  );

  // Microphone models, a new bit after every bclk fall, MSB one bit after ws falls
  always @(negedge audio_clk) begin
    if (!arst_n) begin
      bclk_q = '0;
      pos    = '{0, 0, 0};
      mic_sd = '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (bclk_q[i] && !mic_bclk[i]) begin
          pos[i] = (pos[i] + 1) % 64;
          if (pos[i] == 1) begin
            sent[i] = (hold_mic1 && i == 0) ? HOLD_WORD : 16'($random(seed));
          end
          mic_sd[i] = (pos[i] >= 1 && pos[i] <= 16) ? sent[i][16 - pos[i]] : 1'b0;
        end
      end
      bclk_q = mic_bclk;
    end
  end

  task automatic wait_frames(int n);
    repeat (n) @(posedge mic_ws[0]);
    repeat (2) @(negedge audio_clk);
  endtask

  initial begin
    arst_n    = 1'b0;
    mic_sd    = '0;
    src_sel   = mic_array_pkg::src_mic1;
    spk_en    = 2'b00;
    mode      = 2'd0;
    hold_mic1 = 1'b0;
    sent      = '{16'h0, 16'h0, 16'h0};
    repeat (2) @(negedge audio_clk);
    arst_n = 1'b1;

    wait_frames(8);
    for (int i = 0; i < 3; i++) begin
      u_checker.compare_value($sformatf("capture count mic%0d", i + 1), 8, u_checker.cap_cnt[i]);
    end
    u_checker.end_test("capture");
    u_checker.compare_value("decimation count", u_checker.cap_cnt[0] / 2, u_checker.dec_cnt);
    u_checker.end_test("decimation");

    src_sel = mic_array_pkg::src_tone;
    mode    = 2'd1;
    wait (u_checker.tone_checks >= 20);
    @(negedge audio_clk);
    mode = 2'd0;
    u_checker.end_test("tone");

    src_sel = mic_array_pkg::src_mic1;
    wait_frames(2);
    src_sel = mic_array_pkg::src_dec;
    wait_frames(2);
    src_sel = mic_array_pkg::src_mute;
    wait_frames(1);
    u_checker.end_test("source select");

    hold_mic1 = 1'b1;  // Constant word for the density window
    src_sel   = mic_array_pkg::src_mic1;
    wait_frames(2);
    spk_en = 2'b01;
    @(negedge audio_clk);
    mode = 2'd2;
    wait (u_checker.pdm_done);
    @(negedge audio_clk);
    mode   = 2'd0;
    spk_en = 2'b00;
    repeat (200) @(negedge audio_clk);
    u_checker.end_test("pdm and speaker gating");

    u_checker.summary();
    if (u_checker.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the frames and tone ticks the tests use
  initial begin
    #(LIMIT_NS);
    $display("Timeout: the tests did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* build.f */
common/mic_array_pkg.sv
i2s_rx/i2s_rx.sv
hdl/sine_gen.sv
hdl/decimator.sv
hdl/pdm_mod.sv
hdl/mic_array_top.sv
bench/mic_array_chk.sv
bench/mic_array_checker.sv
bench/mic_array_tb.sv

/* Bender.yml */
package:
  name: mic_array

sources:
  - common/mic_array_pkg.sv
  - i2s_rx/i2s_rx.sv
  - hdl/sine_gen.sv
  - hdl/decimator.sv
  - hdl/pdm_mod.sv
  - hdl/mic_array_top.sv
  - target: test
    files:
      - bench/mic_array_chk.sv
      - bench/mic_array_checker.sv
      - bench/mic_array_tb.sv
